// File: compile.f
src/player_pkg.sv
src/tempo_divider.sv
src/score_sequencer.sv
src/pitch_table.sv
src/tone_generator.sv
src/music_player.sv
tests/tb_music_player.sv

// File: run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --timescale 1ns/10ps \
	-f compile.f --top-module tb_music_player \
	-Mdir "$BUILD" -o sim_music_player
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD/sim_music_player" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
	exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0

// File: src/music_player.sv
`timescale 1ns/10ps
`default_nettype none

module music_player #(
	parameter int TONE_DIV  = player_pkg::TONE_DIV_DEFAULT,
	parameter int TEMPO_DIV = player_pkg::TEMPO_DIV_DEFAULT
) (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic play_n,
	output logic      audio
);

	import player_pkg::*;

	logic      tone_tick;
	logic      step_tick;
	note_t     note;
	tone_cmd_t cmd;

	//////////////////////////////////////////////////////////////////////
	// Enables and decode
	//////////////////////////////////////////////////////////////////////

	tempo_divider #(
		.TONE_DIV  (TONE_DIV),
		.TEMPO_DIV (TEMPO_DIV)
	) tempo_divider_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.tone_tick (tone_tick),
		.step_tick (step_tick)
	);

	score_sequencer score_sequencer_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.step_tick (step_tick),
		.note      (note)
	);

	pitch_table pitch_table_i (
		.clk    (clk),
		.arst_n (arst_n),
		.note   (note),
		.cmd    (cmd)
	);

	//////////////////////////////////////////////////////////////////////
	// Tone output
	//////////////////////////////////////////////////////////////////////

	tone_generator tone_generator_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.tone_tick (tone_tick),
		.cmd       (cmd),
		.play_n    (play_n),
		.audio     (audio)
	);

endmodule

`default_nettype wire

// File: src/pitch_table.sv
`timescale 1ns/10ps
`default_nettype none

module pitch_table (
	input  wire logic              clk,
	input  wire logic              arst_n,
	input  wire player_pkg::note_t note,
	output player_pkg::tone_cmd_t  cmd
);

	import player_pkg::*;

	tone_count_t reload;

	// Higher reload gives a shorter half period
	always_comb begin
		case (note)
			5'd0:    reload = TONE_MAX;
			5'd1:    reload = 14'd4916;
			5'd2:    reload = 14'd6168;
			5'd3:    reload = 14'd7281;
			5'd4:    reload = 14'd7791;
			5'd5:    reload = 14'd8730;
			5'd6:    reload = 14'd9565;
			5'd7:    reload = 14'd10310;
			5'd8:    reload = 14'd10647;
			5'd9:    reload = 14'd11272;
			5'd10:   reload = 14'd11831;
			5'd11:   reload = 14'd12087;
			5'd12:   reload = 14'd12556;
			5'd13:   reload = 14'd12974;
			5'd14:   reload = 14'd13346;
			5'd15:   reload = 14'd13516;
			5'd16:   reload = 14'd13829;
			5'd17:   reload = 14'd14108;
			// Out of order with its neighbours
			5'd18:   reload = 14'd11535;
			5'd19:   reload = 14'd14470;
			5'd20:   reload = 14'd14678;
			5'd21:   reload = 14'd14864;
			default: reload = FALLBACK_RELOAD;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd <= CMD_REST;
		end else begin
			cmd.rest   <= (note == NOTE_REST);
			cmd.reload <= reload;
		end
	end

endmodule

`default_nettype wire

// File: src/player_pkg.sv
`default_nettype none

package player_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and types
	//////////////////////////////////////////////////////////////////////

	localparam int SCORE_LEN = 64;

	localparam int NOTE_W = 5;
	localparam int TONE_W = 14;
	localparam int STEP_W = $clog2(SCORE_LEN);

	typedef logic [NOTE_W-1:0] note_t;
	typedef logic [TONE_W-1:0] tone_count_t;
	typedef logic [STEP_W-1:0] step_t;

	// Rest flag sits above the reload value
	typedef struct packed {
		logic        rest;
		tone_count_t reload;
	} tone_cmd_t;

	//////////////////////////////////////////////////////////////////////
	// Tone and score constants
	//////////////////////////////////////////////////////////////////////

	localparam tone_count_t TONE_MAX        = 14'd16383;
	localparam tone_count_t FALLBACK_RELOAD = 14'd11111;

	localparam note_t NOTE_REST = 5'd0;

	// Silent command, also the state out of reset
	localparam tone_cmd_t CMD_REST = '{rest: 1'b1, reload: TONE_MAX};

	localparam string SCORE_FILE = "src/score.mem";

	// Clock enable ratios
	localparam int TONE_DIV_DEFAULT  = 4;
	localparam int TEMPO_DIV_DEFAULT = 3000000;

endpackage

`default_nettype wire

// File: src/score.mem
// One hex note code per line, step 0 first
// 00 is a rest, 01 to 15 are pitches, 16 and up use the fallback reload
01
00
02
00
03
00
04
00
05
00
06
00
07
00
08
00
09
00
0a
00
0b
00
0c
00
0d
00
0e
00
0f
00
10
00
11
00
12
00
13
00
14
00
15
00
16
00
1f
00
19
00
10
11
12
13
14
15
1c
0f
00
0c
0d
0e
00
09
0a
00

// File: src/score_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module score_sequencer (
	input  wire logic          clk,
	input  wire logic          arst_n,
	input  wire logic          step_tick,
	output player_pkg::note_t  note
);

	import player_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Score memory
	//////////////////////////////////////////////////////////////////////

	note_t score_mem [SCORE_LEN];

	initial begin
		$readmemh(SCORE_FILE, score_mem);
	end

	//////////////////////////////////////////////////////////////////////
	// Step counter
	//////////////////////////////////////////////////////////////////////

	step_t step;
	step_t next_step;

	// Loop back after the last step
	assign next_step = (step == step_t'(SCORE_LEN - 1)) ? '0 : step + 1'b1;

	// Note is read for the step being entered
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step <= '0;
			note <= NOTE_REST;
		end else if (step_tick) begin
			step <= next_step;
			note <= score_mem[next_step];
		end
	end

endmodule

`default_nettype wire

// File: src/tempo_divider.sv
`timescale 1ns/10ps
`default_nettype none

module tempo_divider #(
	parameter int TONE_DIV  = player_pkg::TONE_DIV_DEFAULT,
	parameter int TEMPO_DIV = player_pkg::TEMPO_DIV_DEFAULT
) (
	input  wire logic clk,
	input  wire logic arst_n,
	output logic      tone_tick,
	output logic      step_tick
);

	typedef logic [$clog2(TONE_DIV+1)-1:0]  tone_div_t;
	typedef logic [$clog2(TEMPO_DIV+1)-1:0] tempo_div_t;

	tone_div_t  tone_cnt;
	tempo_div_t tempo_cnt;

	// Count rests at DIV-1 in the cycle before every DIV-th clock,
	// so the enable is sampled on that clock
	assign tone_tick = (tone_cnt == tone_div_t'(TONE_DIV - 1));
	assign step_tick = (tempo_cnt == tempo_div_t'(TEMPO_DIV - 1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tone_cnt <= '0;
		end else if (tone_tick) begin
			tone_cnt <= '0;
		end else begin
			tone_cnt <= tone_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			tempo_cnt <= '0;
		end else if (step_tick) begin
			tempo_cnt <= '0;
		end else begin
			tempo_cnt <= tempo_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/tone_generator.sv
`timescale 1ns/10ps
`default_nettype none

module tone_generator (
	input  wire logic                  clk,
	input  wire logic                  arst_n,
	input  wire logic                  tone_tick,
	input  wire player_pkg::tone_cmd_t cmd,
	input  wire logic                  play_n,
	output logic                       audio
);

	import player_pkg::*;

	//////////////////////////////////////////////////////////////////////
	// Reload counter and audio level
	//////////////////////////////////////////////////////////////////////

	tone_count_t count;
	logic        level;

	// Half period is TONE_MAX+1-reload tone ticks
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= TONE_MAX;
			level <= 1'b1;
		end else if (cmd.rest) begin
			// Silent and parked at the reload value
			count <= cmd.reload;
			level <= 1'b1;
		end else if (tone_tick) begin
			if (count == TONE_MAX) begin
				// New pitch only lands here, at the wrap
				count <= cmd.reload;
				level <= ~level;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Mute
	//////////////////////////////////////////////////////////////////////

	// Counter keeps running underneath
	assign audio = play_n ? 1'b1 : level;

endmodule

`default_nettype wire

// File: tests/tb_music_player.sv
`timescale 1ns/10ps
`default_nettype none

module tb_music_player;

	import player_pkg::*;

	localparam int TONE_DIV     = 1;
	localparam int TEMPO_DIV    = 20000;
	localparam int LOOP_STEPS   = 16;
	localparam int MUTE_WINDOWS = 8;
	localparam int MAX_PRINTED  = 40;
	localparam int WRAP         = int'(TONE_MAX) + 1;

	localparam int TEST_RESET = 0;
	localparam int TEST_PITCH = 1;
	localparam int TEST_REST  = 2;
	localparam int TEST_LOOP  = 3;
	localparam int TEST_MUTE  = 4;
	localparam int NUM_TESTS  = 5;

	logic clk;
	logic arst_n;
	logic play_n;
	logic audio;

	note_t  score [SCORE_LEN];
	int     checks [NUM_TESTS];
	int     errors [NUM_TESTS];
	int     printed;
	int     cycle;
	integer seed;
	bit     timed_out;

	// Edge tracking
	logic prev_audio;
	logic prev_play_n;
	logic edge_valid;
	int   last_edge;

	logic mute_phase;
	int   last_release;
	int   release_checks;
	bit   code_used [32];
	bit   code_seen [32];
	bit   step_seen [SCORE_LEN];
	bit   loop_start_seen;

	music_player #(
		.TONE_DIV  (TONE_DIV),
		.TEMPO_DIV (TEMPO_DIV)
	) dut_i (
		.clk    (clk),
		.arst_n (arst_n),
		.play_n (play_n),
		.audio  (audio)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Clock 1 is the first rising edge out of reset
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle <= 0;
		end else begin
			cycle <= cycle + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Half period in clocks or 0 for a silent note
	function automatic int half_period(input int code);
		int reload;
		case (code)
			0:       reload = WRAP;
			1:       reload = 4916;
			2:       reload = 6168;
			3:       reload = 7281;
			4:       reload = 7791;
			5:       reload = 8730;
			6:       reload = 9565;
			7:       reload = 10310;
			8:       reload = 10647;
			9:       reload = 11272;
			10:      reload = 11831;
			11:      reload = 12087;
			12:      reload = 12556;
			13:      reload = 12974;
			14:      reload = 13346;
			15:      reload = 13516;
			16:      reload = 13829;
			17:      reload = 14108;
			18:      reload = 11535;
			19:      reload = 14470;
			20:      reload = 14678;
			21:      reload = 14864;
			default: reload = 11111;
		endcase
		return (WRAP - reload) * TONE_DIV;
	endfunction

	// Step ticks seen up to and including clock c
	function automatic int step_of(input int c);
		if (c < TEMPO_DIV) begin
			return 0;
		end
		return c / TEMPO_DIV;
	endfunction

	// Note held after clock c with a rest out of reset
	function automatic int note_at(input int c);
		int k;
		k = step_of(c);
		if (k == 0) begin
			return 0;
		end
		return int'(score[k % SCORE_LEN]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic note_error(input int test, input string msg);
		errors[test]++;
		if (printed < MAX_PRINTED) begin
			$display("%s", msg);
		end else if (printed == MAX_PRINTED) begin
			$display("Too many errors, further error lines suppressed");
		end
		printed++;
	endtask

	task automatic expect_high(input int test, input int c, input logic value);
		checks[test]++;
		if (value !== 1'b1) begin
			note_error(test, $sformatf("ERROR audio at clock %0d: got 0x%0h expected 0x1",
				c, value));
		end
	endtask

	// Level edge at clock start loads the reload of note_at(start-2)
	task automatic compare_interval(input int start, input int stop);
		int    k;
		int    code;
		int    expected;
		int    test;
		string where;
		k = step_of(start - 2);
		code = note_at(start - 2);
		if (code != 0 && step_of(stop - 2) == k) begin
			expected = half_period(code);
			if (k < SCORE_LEN) begin
				test = TEST_PITCH;
			end else if (mute_phase) begin
				test = TEST_MUTE;
			end else begin
				test = TEST_LOOP;
			end
			checks[test]++;
			if (test == TEST_MUTE && last_release > 0 && start > last_release) begin
				release_checks++;
			end
			if (stop - start != expected) begin
				where = $sformatf("clock %0d, step %0d, note 0x%0h",
					start, k % SCORE_LEN, code);
				note_error(test, $sformatf(
					"ERROR audio half period at %s: got 0x%0h expected 0x%0h",
					where, stop - start, expected));
			end else begin
				code_seen[code] = 1'b1;
				if (k < SCORE_LEN) begin
					step_seen[k] = 1'b1;
				end
				if (k == SCORE_LEN) begin
					loop_start_seen = 1'b1;
				end
			end
		end
	endtask

	task automatic verify_score();
		bit above;
		above = 1'b0;
		for (int i = 0; i < SCORE_LEN; i++) begin
			code_used[score[i]] = 1'b1;
			if (score[i] > 5'd21) begin
				above = 1'b1;
			end
		end
		for (int code = 0; code <= 21; code++) begin
			if (!code_used[code]) begin
				note_error(TEST_PITCH, $sformatf("Score has no step with note code %0d", code));
			end
		end
		if (!above) begin
			note_error(TEST_PITCH, "Score has no note code that uses the fallback reload");
		end
	endtask

	task automatic report_test(input int test, input string name);
		$display("%s test finished: %0d checks, %0d errors", name, checks[test], errors[test]);
	endtask

	task automatic wait_until_cycle(input int target);
		int limit;
		int waited;
		limit = target - cycle + 16;
		waited = 0;
		while (cycle < target && waited < limit) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (cycle < target) begin
			$display("Timeout: clock count stuck at %0d while waiting for %0d", cycle, target);
			timed_out = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Monitor sampling mid cycle
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic sampled_audio;
		logic sampled_play_n;
		int   c;
		sampled_audio = audio;
		sampled_play_n = play_n;
		c = cycle;
		if (arst_n && c >= 1) begin
			if (sampled_play_n) begin
				edge_valid = 1'b0;
				expect_high(TEST_MUTE, c, sampled_audio);
			end else if (note_at(c - 2) == 0) begin
				if (step_of(c - 2) == 0) begin
					expect_high(TEST_RESET, c, sampled_audio);
				end else begin
					expect_high(TEST_REST, c, sampled_audio);
				end
			end
			if (sampled_audio != prev_audio) begin
				// Edges made by the mute gate carry no pitch
				if (sampled_play_n || prev_play_n) begin
					edge_valid = 1'b0;
				end else begin
					if (edge_valid) begin
						compare_interval(last_edge, c);
					end
					last_edge = c;
					edge_valid = 1'b1;
				end
			end
		end
		prev_audio = sampled_audio;
		prev_play_n = sampled_play_n;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// Test phases in order, left early on a timeout
	task automatic run_phases();
		int gap;
		int len;
		wait_until_cycle(TEMPO_DIV + 2);
		if (timed_out) begin
			return;
		end
		report_test(TEST_RESET, "reset");

		// First pass over steps 1 to SCORE_LEN-1
		wait_until_cycle(SCORE_LEN * TEMPO_DIV + 2);
		if (timed_out) begin
			return;
		end
		for (int k = 1; k < SCORE_LEN; k++) begin
			if (score[k] != 0 && !step_seen[k]) begin
				note_error(TEST_PITCH, $sformatf("Step %0d gave no measurable half period", k));
			end
		end
		report_test(TEST_PITCH, "pitch");

		wait_until_cycle((SCORE_LEN + LOOP_STEPS) * TEMPO_DIV + 2);
		if (timed_out) begin
			return;
		end
		if (!loop_start_seen) begin
			note_error(TEST_LOOP, "Step 0 gave no measurable half period on the second pass");
		end
		for (int code = 1; code < 32; code++) begin
			if (code_used[code] && !code_seen[code]) begin
				note_error(TEST_LOOP, $sformatf("Note code %0d was never measured", code));
			end
		end
		report_test(TEST_LOOP, "loop");

		mute_phase = 1'b1;
		for (int w = 0; w < MUTE_WINDOWS; w++) begin
			gap = 3000 + int'({$random(seed)} % 32'd12000);
			len = 1000 + int'({$random(seed)} % 32'd20000);
			wait_until_cycle(cycle + gap);
			if (timed_out) begin
				return;
			end
			play_n = 1'b1;
			wait_until_cycle(cycle + len);
			if (timed_out) begin
				return;
			end
			play_n = 1'b0;
			last_release = cycle;
		end
		wait_until_cycle(cycle + TEMPO_DIV);
		if (timed_out) begin
			return;
		end
		if (release_checks == 0) begin
			note_error(TEST_MUTE, "No half period was measured after a mute release");
		end
		report_test(TEST_MUTE, "mute");
		report_test(TEST_REST, "rest");
	endtask

	initial begin
		int total_checks;
		int total_errors;
		seed = 32'h8a8bf844;
		arst_n = 1'b0;
		play_n = 1'b0;
		timed_out = 1'b0;
		mute_phase = 1'b0;
		prev_audio = 1'b1;
		prev_play_n = 1'b0;
		edge_valid = 1'b0;
		last_edge = 0;
		last_release = 0;
		release_checks = 0;
		printed = 0;
		loop_start_seen = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			checks[t] = 0;
			errors[t] = 0;
		end
		$readmemh(SCORE_FILE, score);
		verify_score();

		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;

		run_phases();

		total_checks = 0;
		total_errors = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			total_checks += checks[t];
			total_errors += errors[t];
		end
		$display("%0d tests finished, %0d checks, %0d errors",
			NUM_TESTS, total_checks, total_errors);
		if (!timed_out && total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
